//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_imgproc_core
FILELIST  = imgproc.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/imgproc_defs.svh
`ifndef IMGPROC_DEFS_SVH
`define IMGPROC_DEFS_SVH

// image geometry
`define IMG_DIM 8 // pixels per side, x and y
`define IMG_CHANNELS 32 // channels per pixel position

// data widths
`define PIXEL_W 8 // stored pixel
`define OUT_W 14 // output bus, pixel is zero-extended
`define OP_W 4 // opcode field

// index widths
`define COORD_W 3 // enough for 0..IMG_DIM-1
`define CHAN_W 5 // enough for 0..IMG_CHANNELS-1

// largest origin so a 2x2 window stays inside the image
`define ORIGIN_MAX 6

`endif

//--- common/imgproc_pkg.sv
`include "imgproc_defs.svh"

package imgproc_pkg;

	typedef logic [`COORD_W-1:0] coord_t; // x or y position, 0-based
	typedef logic [`CHAN_W-1:0]  chan_t; // channel index
	typedef logic [`PIXEL_W-1:0] pixel_t; // one stored byte
	typedef logic [`OUT_W-1:0]   out_t; // output word

	// channel window depth
	typedef enum logic [1:0] {
		WIN_8  = 2'd0,
		WIN_16 = 2'd1,
		WIN_32 = 2'd2
	} window_e;

	// op codes, 8..15 are left undecoded
	typedef enum logic [`OP_W-1:0] {
		OP_LOAD       = 4'd0,
		OP_RIGHT      = 4'd1, // origin x + 1
		OP_LEFT       = 4'd2, // origin x - 1
		OP_UP         = 4'd3, // origin y - 1
		OP_DOWN       = 4'd4, // origin y + 1
		OP_SCALE_DOWN = 4'd5,
		OP_SCALE_UP   = 4'd6,
		OP_DISPLAY    = 4'd7
	} opcode_e;

	// sequencer FSM
	typedef enum logic [2:0] {
		S_READY   = 3'd0, // single-cycle op_ready pulse
		S_WAIT_OP = 3'd1,
		S_LOAD    = 3'd2,
		S_APPLY   = 3'd3, // shift or scale
		S_DISPLAY = 3'd4,
		S_FINISH  = 3'd5
	} seq_state_e;

endpackage

//--- display/scan_addr_gen.sv
`include "imgproc_defs.svh"

module scan_addr_gen (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_start,
	input  imgproc_pkg::coord_t  i_origin_x,
	input  imgproc_pkg::coord_t  i_origin_y,
	input  imgproc_pkg::window_e i_window,
	output logic                 o_rd_en,
	output imgproc_pkg::coord_t  o_rd_x,
	output imgproc_pkg::coord_t  o_rd_y,
	output imgproc_pkg::chan_t   o_rd_ch,
	output logic                 o_done
);
	logic               busy; // walk in progress
	logic               dx, dy; // offset inside the 2x2 window
	imgproc_pkg::chan_t ch, ch_last;
	logic [`COORD_W:0]  rd_x_full, rd_y_full; // one extra bit to catch overflow
	logic               last;

	always_comb begin
		case (i_window)
			imgproc_pkg::WIN_8:  ch_last = imgproc_pkg::chan_t'(7);
			imgproc_pkg::WIN_16: ch_last = imgproc_pkg::chan_t'(15);
			default:             ch_last = imgproc_pkg::chan_t'(31);
		endcase
	end

	assign rd_x_full = {1'b0, i_origin_x} + {{`COORD_W{1'b0}}, dx};
	assign rd_y_full = {1'b0, i_origin_y} + {{`COORD_W{1'b0}}, dy};
	assign last      = busy && dx && dy && (ch == ch_last); // bottom-right of final channel

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			dx   <= 1'b0;
			dy   <= 1'b0;
			ch   <= '0;
		end else if (i_start) begin
			busy <= 1'b1;
			dx   <= 1'b0;
			dy   <= 1'b0;
			ch   <= '0;
		end else if (busy) begin
			dx <= ~dx; // x fastest
			if (dx)
				dy <= ~dy;
			if (dx && dy)
				ch <= ch + 1'b1; // next channel after 4 reads
			if (last)
				busy <= 1'b0;
		end
	end

	assign o_rd_en = busy;
	assign o_rd_x  = rd_x_full[`COORD_W-1:0];
	assign o_rd_y  = rd_y_full[`COORD_W-1:0];
	assign o_rd_ch = ch;
	assign o_done  = last; // same cycle as the final read

	// origin saturation in the sequencer keeps the window inside the image
	a_rd_in_bounds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_en |-> (rd_x_full <= (`IMG_DIM - 1)) && (rd_y_full <= (`IMG_DIM - 1)));

endmodule

//--- imgproc.f
+incdir+common
common/imgproc_pkg.sv
logic/op_sequencer.sv
display/scan_addr_gen.sv
logic/image_store.sv
logic/imgproc_core.sv
tb/tb_imgproc_core.sv

//--- logic/image_store.sv
`include "imgproc_defs.svh"

module image_store (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_wr_en,
	input  imgproc_pkg::coord_t i_wr_x,
	input  imgproc_pkg::coord_t i_wr_y,
	input  imgproc_pkg::chan_t  i_wr_ch,
	input  imgproc_pkg::pixel_t i_wr_data,
	input  logic                i_rd_en,
	input  imgproc_pkg::coord_t i_rd_x,
	input  imgproc_pkg::coord_t i_rd_y,
	input  imgproc_pkg::chan_t  i_rd_ch,
	output logic                o_out_valid,
	output imgproc_pkg::out_t   o_out_data
);
	localparam int ADDR_W = `CHAN_W + 2 * `COORD_W; // {ch, y, x}
	localparam int DEPTH  = `IMG_CHANNELS * `IMG_DIM * `IMG_DIM;

	imgproc_pkg::pixel_t mem [0:DEPTH-1];
	imgproc_pkg::pixel_t rd_data_q;
	logic                rd_valid_q;
	logic [ADDR_W-1:0]   wr_addr, rd_addr;

	assign wr_addr = {i_wr_ch, i_wr_y, i_wr_x};
	assign rd_addr = {i_rd_ch, i_rd_y, i_rd_x};

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			mem[wr_addr] <= i_wr_data;
		if (i_rd_en)
			rd_data_q <= mem[rd_addr]; // registered read, one cycle latency
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= i_rd_en; // valid tracks the read by one cycle
	end

	assign o_out_valid = rd_valid_q;
	assign o_out_data  = imgproc_pkg::out_t'(rd_data_q); // zero-extend 8 -> 14

	// load and display never overlap, the sequencer serializes them
	a_no_rw_overlap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_wr_en && i_rd_en));

endmodule

//--- logic/imgproc_core.sv
module imgproc_core (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_op_valid,
	input  imgproc_pkg::opcode_e i_op_mode,
	input  logic                 i_in_valid,
	input  imgproc_pkg::pixel_t  i_in_data,
	output logic                 o_op_ready,
	output logic                 o_in_ready,
	output logic                 o_out_valid,
	output imgproc_pkg::out_t    o_out_data
);
	logic                 wr_en; // sequencer -> store
	imgproc_pkg::coord_t  wr_x, wr_y;
	imgproc_pkg::chan_t   wr_ch;
	imgproc_pkg::pixel_t  wr_data;
	logic                 scan_start, scan_done; // sequencer <-> scan
	imgproc_pkg::coord_t  origin_x, origin_y;
	imgproc_pkg::window_e window;
	logic                 rd_en; // scan -> store
	imgproc_pkg::coord_t  rd_x, rd_y;
	imgproc_pkg::chan_t   rd_ch;

	op_sequencer op_sequencer_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_op_valid   (i_op_valid),
		.i_op_mode    (i_op_mode),
		.i_in_valid   (i_in_valid),
		.i_in_data    (i_in_data),
		.i_scan_done  (scan_done),
		.o_op_ready   (o_op_ready),
		.o_in_ready   (o_in_ready),
		.o_wr_en      (wr_en),
		.o_wr_x       (wr_x),
		.o_wr_y       (wr_y),
		.o_wr_ch      (wr_ch),
		.o_wr_data    (wr_data),
		.o_scan_start (scan_start),
		.o_origin_x   (origin_x),
		.o_origin_y   (origin_y),
		.o_window     (window)
	);

	scan_addr_gen scan_addr_gen_inst (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (scan_start),
		.i_origin_x (origin_x),
		.i_origin_y (origin_y),
		.i_window   (window),
		.o_rd_en    (rd_en),
		.o_rd_x     (rd_x),
		.o_rd_y     (rd_y),
		.o_rd_ch    (rd_ch),
		.o_done     (scan_done)
	);

	image_store image_store_inst (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wr_en     (wr_en),
		.i_wr_x      (wr_x),
		.i_wr_y      (wr_y),
		.i_wr_ch     (wr_ch),
		.i_wr_data   (wr_data),
		.i_rd_en     (rd_en),
		.i_rd_x      (rd_x),
		.i_rd_y      (rd_y),
		.i_rd_ch     (rd_ch),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

//--- logic/op_sequencer.sv
`include "imgproc_defs.svh"

module op_sequencer (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_op_valid,
	input  imgproc_pkg::opcode_e i_op_mode,
	input  logic                 i_in_valid,
	input  imgproc_pkg::pixel_t  i_in_data,
	input  logic                 i_scan_done,
	output logic                 o_op_ready,
	output logic                 o_in_ready,
	output logic                 o_wr_en,
	output imgproc_pkg::coord_t  o_wr_x,
	output imgproc_pkg::coord_t  o_wr_y,
	output imgproc_pkg::chan_t   o_wr_ch,
	output imgproc_pkg::pixel_t  o_wr_data,
	output logic                 o_scan_start,
	output imgproc_pkg::coord_t  o_origin_x,
	output imgproc_pkg::coord_t  o_origin_y,
	output imgproc_pkg::window_e o_window
);
	imgproc_pkg::seq_state_e state, state_nxt;
	logic                    op_valid_q; // input stage, one cycle late
	imgproc_pkg::opcode_e    op_mode_q;
	logic                    in_valid_q;
	imgproc_pkg::pixel_t     in_data_q;
	imgproc_pkg::opcode_e    op_q; // op kept for S_APPLY
	imgproc_pkg::coord_t     ld_x, ld_y; // load position, x fastest
	imgproc_pkg::chan_t      ld_ch;
	imgproc_pkg::coord_t     origin_x, origin_y;
	imgproc_pkg::window_e    window_q;
	logic                    op_accept, px_accept, ld_x_end, ld_y_end, ld_last;

	assign op_accept = (state == imgproc_pkg::S_WAIT_OP) && op_valid_q;
	assign px_accept = (state == imgproc_pkg::S_LOAD) && in_valid_q;
	assign ld_x_end  = ld_x == imgproc_pkg::coord_t'(`IMG_DIM - 1);
	assign ld_y_end  = ld_y == imgproc_pkg::coord_t'(`IMG_DIM - 1);
	assign ld_last   = ld_x_end && ld_y_end && (ld_ch == imgproc_pkg::chan_t'(`IMG_CHANNELS - 1));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op_valid_q <= 1'b0;
			in_valid_q <= 1'b0;
		end else begin
			op_valid_q <= i_op_valid; // strobes outside S_WAIT_OP/S_LOAD fall through
			in_valid_q <= i_in_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		op_mode_q <= i_op_mode;
		in_data_q <= i_in_data;
		if (op_accept)
			op_q <= op_mode_q; // i_op_mode may change after the strobe
	end

	always_comb begin
		state_nxt = state;
		case (state)
			imgproc_pkg::S_READY:   state_nxt = imgproc_pkg::S_WAIT_OP;
			imgproc_pkg::S_WAIT_OP: begin
				if (op_valid_q) begin
					case (op_mode_q)
						imgproc_pkg::OP_LOAD:    state_nxt = imgproc_pkg::S_LOAD;
						imgproc_pkg::OP_DISPLAY: state_nxt = imgproc_pkg::S_DISPLAY;
						imgproc_pkg::OP_RIGHT,
						imgproc_pkg::OP_LEFT,
						imgproc_pkg::OP_UP,
						imgproc_pkg::OP_DOWN,
						imgproc_pkg::OP_SCALE_DOWN,
						imgproc_pkg::OP_SCALE_UP: state_nxt = imgproc_pkg::S_APPLY;
						default:                  state_nxt = imgproc_pkg::S_READY; // 8..15 ignored
					endcase
				end
			end
			imgproc_pkg::S_LOAD: begin
				if (px_accept && ld_last)
					state_nxt = imgproc_pkg::S_FINISH; // 2048th pixel written
			end
			imgproc_pkg::S_APPLY:   state_nxt = imgproc_pkg::S_FINISH;
			imgproc_pkg::S_DISPLAY: begin
				if (i_scan_done)
					state_nxt = imgproc_pkg::S_FINISH; // last read out, data lands next cycle
			end
			default:                state_nxt = imgproc_pkg::S_READY;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= imgproc_pkg::S_FINISH; // first ready pulse one cycle after reset
			ld_x     <= '0;
			ld_y     <= '0;
			ld_ch    <= '0;
			origin_x <= '0;
			origin_y <= '0;
			window_q <= imgproc_pkg::WIN_32;
		end else begin
			state <= state_nxt;
			if (op_accept && (op_mode_q == imgproc_pkg::OP_LOAD)) begin
				ld_x  <= '0;
				ld_y  <= '0;
				ld_ch <= '0;
			end else if (px_accept) begin
				ld_x <= ld_x + 1'b1; // wraps back to 0 at the row end
				if (ld_x_end)
					ld_y <= ld_y + 1'b1;
				if (ld_x_end && ld_y_end)
					ld_ch <= ld_ch + 1'b1;
			end
			if (state == imgproc_pkg::S_APPLY) begin
				case (op_q)
					imgproc_pkg::OP_RIGHT: begin
						if (origin_x != imgproc_pkg::coord_t'(`ORIGIN_MAX))
							origin_x <= origin_x + 1'b1;
					end
					imgproc_pkg::OP_LEFT: begin
						if (origin_x != '0)
							origin_x <= origin_x - 1'b1;
					end
					imgproc_pkg::OP_UP: begin
						if (origin_y != '0)
							origin_y <= origin_y - 1'b1; // up is toward row 0
					end
					imgproc_pkg::OP_DOWN: begin
						if (origin_y != imgproc_pkg::coord_t'(`ORIGIN_MAX))
							origin_y <= origin_y + 1'b1;
					end
					imgproc_pkg::OP_SCALE_DOWN: window_q <= (window_q == imgproc_pkg::WIN_32) ?
						imgproc_pkg::WIN_16 : imgproc_pkg::WIN_8; // floor at 8
					imgproc_pkg::OP_SCALE_UP: window_q <= (window_q == imgproc_pkg::WIN_8) ?
						imgproc_pkg::WIN_16 : imgproc_pkg::WIN_32; // ceiling at 32
					default: ;
				endcase
			end
		end
	end

	assign o_op_ready   = state == imgproc_pkg::S_READY;
	assign o_in_ready   = state == imgproc_pkg::S_LOAD;
	assign o_wr_en      = px_accept;
	assign o_wr_x       = ld_x;
	assign o_wr_y       = ld_y;
	assign o_wr_ch      = ld_ch;
	assign o_wr_data    = in_data_q;
	assign o_scan_start = op_accept && (op_mode_q == imgproc_pkg::OP_DISPLAY);
	assign o_origin_x   = origin_x;
	assign o_origin_y   = origin_y;
	assign o_window     = window_q;

	// state register never leaves the legal encodings
	a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		state inside {imgproc_pkg::S_READY, imgproc_pkg::S_WAIT_OP, imgproc_pkg::S_LOAD,
			imgproc_pkg::S_APPLY, imgproc_pkg::S_DISPLAY, imgproc_pkg::S_FINISH});

	// load handshake closes only right after the write of the last pixel
	a_load_ends_on_last: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(o_in_ready) |-> $past(o_wr_en && ld_last));

endmodule

//--- tb/tb_imgproc_core.sv
module tb_imgproc_core;
	localparam int TIMEOUT = 1000; // cycles allowed for any single wait

	logic                 i_clk;
	logic                 i_rst_n;
	logic                 i_op_valid;
	imgproc_pkg::opcode_e i_op_mode;
	logic                 i_in_valid;
	imgproc_pkg::pixel_t  i_in_data;
	logic                 o_op_ready;
	logic                 o_in_ready;
	logic                 o_out_valid;
	imgproc_pkg::out_t    o_out_data;

	int unsigned lcg_state;
	logic [7:0]  model_img [0:31][0:7][0:7]; // [channel][y][x]
	int          org_x, org_y, win_size; // model origin and channel window
	logic [13:0] out_q [$]; // outputs seen since the last op

	imgproc_core imgproc_core_inst (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_op_ready  (o_op_ready),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	always #2 i_clk = ~i_clk; // period 4

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8; // low bits of an lcg are weak
	endfunction

	task automatic report_failure(string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// collects outputs until the next op_ready pulse, sampled on the falling edge
	task automatic run_until_ready();
		int cycles;
		out_q.delete();
		for (cycles = 0; cycles < TIMEOUT; cycles++) begin
			@(negedge i_clk);
			if (o_out_valid === 1'b1)
				out_q.push_back(o_out_data);
			if (o_op_ready === 1'b1)
				break;
		end
		if (cycles == TIMEOUT)
			report_failure("timed out waiting for o_op_ready");
	endtask

	// called right after a ready pulse was seen
	task automatic issue_op(imgproc_pkg::opcode_e op);
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b1;
		i_op_mode  = op;
		@(posedge i_clk);
		#1;
		i_op_valid = 1'b0; // single-cycle strobe
	endtask

	task automatic load_image();
		int cycles, gap;
		for (int c = 0; c < 32; c++)
			for (int y = 0; y < 8; y++)
				for (int x = 0; x < 8; x++)
					model_img[c][y][x] = 8'(lcg_next());
		issue_op(imgproc_pkg::OP_LOAD);
		for (cycles = 0; cycles < TIMEOUT; cycles++) begin
			@(negedge i_clk);
			if (o_in_ready === 1'b1)
				break;
		end
		if (cycles == TIMEOUT)
			report_failure("timed out waiting for o_in_ready after the load op");
		for (int c = 0; c < 32; c++)
			for (int y = 0; y < 8; y++)
				for (int x = 0; x < 8; x++) begin // x fastest, then y, then channel
					gap = lcg_next() % 4;
					repeat (gap) begin
						@(posedge i_clk);
						#1;
						i_in_valid = 1'b0;
					end
					@(posedge i_clk);
					#1;
					i_in_valid = 1'b1;
					i_in_data  = model_img[c][y][x];
				end
		@(posedge i_clk);
		#1;
		i_in_valid = 1'b0;
		run_until_ready();
		check_value("load out count", out_q.size(), 0); // a load streams nothing out
		check_value("o_in_ready", o_in_ready, 1'b0);
	endtask

	// shift, scale or undecoded op, with the model updated by the same rule
	task automatic apply_op(imgproc_pkg::opcode_e op);
		issue_op(op);
		run_until_ready();
		check_value("op out count", out_q.size(), 0);
		case (op)
			imgproc_pkg::OP_RIGHT:      if (org_x < 6) org_x++;
			imgproc_pkg::OP_LEFT:       if (org_x > 0) org_x--;
			imgproc_pkg::OP_UP:         if (org_y > 0) org_y--; // up is toward row 0
			imgproc_pkg::OP_DOWN:       if (org_y < 6) org_y++;
			imgproc_pkg::OP_SCALE_DOWN: if (win_size > 8) win_size = win_size / 2;
			imgproc_pkg::OP_SCALE_UP:   if (win_size < 32) win_size = win_size * 2;
			default: ; // 8..15 change nothing
		endcase
	endtask

	task automatic display_and_check();
		int k;
		issue_op(imgproc_pkg::OP_DISPLAY);
		run_until_ready();
		check_value("display out count", out_q.size(), 4 * win_size);
		k = 0;
		for (int c = 0; c < win_size; c++)
			for (int y = org_y; y <= org_y + 1; y++)
				for (int x = org_x; x <= org_x + 1; x++) begin
					check_value($sformatf("o_out_data[%0d]", k), out_q[k], model_img[c][y][x]);
					k++;
				end
	endtask

	initial begin
		logic [3:0] mode;
		int         run_len;
		lcg_state  = 91510;
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = imgproc_pkg::OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		org_x      = 0;
		org_y      = 0;
		win_size   = 32;
		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
		check_value("o_op_ready", o_op_ready, 1'b0); // all handshake outputs quiet in reset
		check_value("o_in_ready", o_in_ready, 1'b0);
		check_value("o_out_valid", o_out_valid, 1'b0);
		@(posedge i_clk);
		#1;
		i_rst_n = 1'b1; // fifth cycle done
		run_until_ready();
		check_value("reset out count", out_q.size(), 0);

		load_image();
		display_and_check(); // reset defaults, 128 values

		repeat (20) begin // shift runs long enough to hit the edges
			mode    = 4'(1 + lcg_next() % 4);
			run_len = 1 + lcg_next() % 8;
			repeat (run_len) apply_op(imgproc_pkg::opcode_e'(mode));
			display_and_check();
		end

		repeat (3) begin
			apply_op(imgproc_pkg::OP_SCALE_DOWN); // third one is past the floor
			display_and_check();
		end
		repeat (3) begin
			apply_op(imgproc_pkg::OP_SCALE_UP);
			display_and_check();
		end
		repeat (8) begin
			mode = lcg_next() % 2 ? 4'd5 : 4'd6;
			apply_op(imgproc_pkg::opcode_e'(mode));
			display_and_check();
		end

		for (int m = 8; m < 16; m++) begin
			mode = 4'(m);
			apply_op(imgproc_pkg::opcode_e'(mode)); // ignored, straight back to ready
			display_and_check();
		end

		load_image(); // replaces every byte of the first image
		display_and_check();
		apply_op(imgproc_pkg::OP_DOWN);
		apply_op(imgproc_pkg::OP_SCALE_DOWN);
		display_and_check();

		$display("TEST PASS");
		$finish;
	end

endmodule
